/* filelist.f */
+incdir+include
verilog/iob_soc_pkg.sv
verilog/iob_split.sv
verilog/int_mem.sv
verilog/ext_mem.sv
verilog/periph_regs.sv
verilog/iob_soc.sv
test/iob_soc_tb.sv

/* include/iob_soc_consts.svh */
`ifndef IOB_SOC_CONSTS_SVH
`define IOB_SOC_CONSTS_SVH

// cpu bus widths
`define ADDR_W 32
`define DATA_W 32

// internal sram depth in words (1024)
`define SRAM_ADDR_W 10
// word address width seen by the external memory port
`define EXT_ADDR_W 16

// address map select bits
`define E_BIT 31
`define P_BIT 30

// peripheral register word offsets
`define REG_SCRATCH 0
`define REG_TIMER 1
`define REG_GPIO 2

`define GPIO_W 8

`endif

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
   --top-module iob_soc_tb -o sim_iob_soc
./obj_dir/sim_iob_soc | tee sim.log

if grep -q "\*\*\* TEST PASSED \*\*\*" sim.log; then
   exit 0
fi
exit 1

/* test/iob_soc_tb.sv */
`default_nettype none

`include "iob_soc_consts.svh"

module iob_soc_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import iob_soc_pkg::*;

   localparam int PERIOD = 100;
   // the tests need about a thousand cycles, generous margin on top
   localparam int MAX_CYCLES = 20000;
   localparam logic [31:0] SEED = 32'hc4ec_5b6a;

   logic               clk_i = 1'b0;
   logic               rst_n_i;
   iob_req_t           ibus_req;
   iob_resp_t          ibus_resp;
   iob_req_t           dbus_req;
   iob_resp_t          dbus_resp;
   ext_req_t           ext_req;
   logic               ext_ack;
   logic [`DATA_W-1:0] ext_rdata;
   logic [`GPIO_W-1:0] gpio_o;

   logic [31:0] cyc = 0;
   logic [31:0] delay_rng = SEED;
   logic [31:0] stim_rng = SEED;
   int          ext_wait = 0;
   logic [31:0] ext_model[int];
   logic [31:0] sram_ref[int];
   ext_req_t    ext_log[$];
   // {rvalid cycle, rdata} per bus
   logic [63:0] iq[$];
   logic [63:0] dq[$];

   logic        chk_en = 1'b0;
   string       chk_name;
   logic [31:0] chk_exp;
   logic [31:0] chk_act;
   string       test_name;
   int          checks = 0;
   int          errors = 0;
   int          test_errs = 0;
   int          tests = 0;
   int          failed_tests = 0;

   iob_soc DUT (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .ibus_req_i (ibus_req),
      .ibus_resp_o(ibus_resp),
      .dbus_req_i (dbus_req),
      .dbus_resp_o(dbus_resp),
      .ext_req_o  (ext_req),
      .ext_ack_i  (ext_ack),
      .ext_rdata_i(ext_rdata),
      .gpio_o     (gpio_o)
   );

   always #(PERIOD / 2) clk_i = ~clk_i;

   always @(posedge clk_i) cyc <= cyc + 1;

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] wdata,
                                         input logic [3:0] strb);
      logic [31:0] r;
      r = old;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) r[8*b+:8] = wdata[8*b+:8];
      end
      return r;
   endfunction

   function automatic logic [31:0] ext_word(input logic [31:0] waddr);
      return ext_model.exists(int'(waddr)) ? ext_model[int'(waddr)] : 32'h0;
   endfunction

   assert property (@(posedge clk_i) chk_en |-> (chk_act == chk_exp))
      else begin
         $display("Fail %s (%s): expected %h, actual %h", test_name, chk_name, chk_exp,
                  chk_act);
         errors++;
         test_errs++;
      end

   assert property (@(posedge clk_i) !rst_n_i |=> (!ibus_resp.rvalid && !dbus_resp.rvalid
                                                  && !ext_req.valid && (gpio_o == '0)))
      else begin
         $display("an rvalid, ext valid or gpio was not cleared by reset");
         errors++;
         test_errs++;
      end

   assert property (@(posedge clk_i) disable iff (!rst_n_i)
                    (ext_req.valid && !ext_ack) |=> (ext_req.valid && $stable(ext_req)))
      else begin
         $display("ext request dropped or changed before its acknowledge");
         errors++;
         test_errs++;
      end

   // rvalid collection, read back in issue order
   always @(negedge clk_i) begin
      if (ibus_resp.rvalid) iq.push_back({cyc, ibus_resp.rdata});
      if (dbus_resp.rvalid) dq.push_back({cyc, dbus_resp.rdata});
   end

   // external memory, acknowledge after 1 to 4 cycles
   always @(negedge clk_i) begin
      logic [31:0] old;
      if (!rst_n_i || !ext_req.valid || ext_ack) begin
         ext_ack  = 1'b0;
         ext_wait = 0;
      end else begin
         if (ext_wait == 0) begin
            delay_rng = xorshift(delay_rng);
            ext_wait  = 1 + int'(delay_rng % 4);
         end
         ext_wait--;
         if (ext_wait == 0) begin
            old       = ext_word(32'(ext_req.addr));
            ext_rdata = old;
            if (ext_req.we) ext_model[int'(ext_req.addr)] = merge(old, ext_req.wdata,
                                                                  ext_req.wstrb);
            ext_log.push_back(ext_req);
            ext_ack = 1'b1;
         end
      end
   end

   initial begin
      repeat (MAX_CYCLES) @(posedge clk_i);
      $display("timeout after %0d cycles in test %s", MAX_CYCLES, test_name);
      $display("*** TEST FAILED ***");
      $finish;
   end

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      chk_name = name;
      chk_exp  = exp;
      chk_act  = act;
      chk_en   = 1'b1;
      checks++;
      @(negedge clk_i);
      chk_en = 1'b0;
   endtask

   // bus 0 is ibus, bus 1 is dbus; returns on the falling edge after acceptance
   task automatic issue(input int bus, input logic [31:0] addr, input logic [31:0] wdata,
                        input logic [3:0] strb, output logic [31:0] acc);
      iob_req_t r;
      logic     rdy;
      r = '{avalid: 1'b1, addr: addr, wdata: wdata, wstrb: strb};
      if (bus == 0) ibus_req = r;
      else dbus_req = r;
      while (1) begin
         #(PERIOD / 4);
         rdy = (bus == 0) ? ibus_resp.ready : dbus_resp.ready;
         if (rdy) break;
         @(negedge clk_i);
      end
      @(negedge clk_i);
      acc = cyc;
      if (bus == 0) ibus_req = '0;
      else dbus_req = '0;
   endtask

   task automatic take(input int bus, output logic [31:0] data, output logic [31:0] rv);
      logic [63:0] e;
      if (bus == 0) begin
         while (iq.size() == 0) @(negedge clk_i);
         e = iq.pop_front();
      end else begin
         while (dq.size() == 0) @(negedge clk_i);
         e = dq.pop_front();
      end
      data = e[31:0];
      rv   = e[63:32];
   endtask

   task automatic read(input int bus, input logic [31:0] addr, output logic [31:0] data,
                       output logic [31:0] acc, output logic [31:0] rv);
      issue(bus, addr, '0, '0, acc);
      take(bus, data, rv);
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_errs = 0;
   endtask

   task automatic end_test();
      tests++;
      if (test_errs != 0) failed_tests++;
      $display("test %s: %s (%0d errors)", test_name, (test_errs == 0) ? "ok" : "failed",
               test_errs);
   endtask

   initial begin
      logic [31:0] a;
      logic [31:0] v;
      logic [31:0] d;
      logic [31:0] d2;
      logic [31:0] acc;
      logic [31:0] acc2;
      logic [31:0] rv;
      logic [31:0] rv2;
      logic [3:0]  strb;
      int          n;
      ibus_req  = '0;
      dbus_req  = '0;
      ext_ack   = 1'b0;
      ext_rdata = '0;
      rst_n_i   = 1'b0;
      start_test("reset");
      repeat (16) @(negedge clk_i);
      rst_n_i = 1'b1;
      @(negedge clk_i);

      check("reset outputs", '0, {ibus_resp.rvalid, dbus_resp.rvalid, ext_req.valid, gpio_o});
      end_test();

      start_test("sram");
      for (int i = 0; i < 4; i++) begin
         a = 32'h0000_0100 + 4 * i;
         v = 32'h1122_3344 ^ (i * 32'h0101_0101);
         issue(1, a, v, 4'hf, acc);
         // partial write merges one byte per word
         strb = 4'b0001 << i;
         issue(1, a, 32'haabb_ccdd, strb, acc);
         sram_ref[i] = merge(v, 32'haabb_ccdd, strb);
      end
      for (int i = 0; i < 4; i++) begin
         a = 32'h0000_0100 + 4 * i;
         read(1, a, d, acc, rv);
         check("sram dbus data", sram_ref[i], d);
         check("sram dbus latency", 1, rv - acc + 1);
         read(0, a, d, acc, rv);
         check("sram ibus data", sram_ref[i], d);
         check("sram ibus latency", 1, rv - acc + 1);
      end
      end_test();

      start_test("ext");
      for (int i = 0; i < 6; i++) begin
         stim_rng = xorshift(stim_rng);
         a        = 32'h8000_0000 | (stim_rng & 32'h0003_fffc);
         stim_rng = xorshift(stim_rng);
         v        = stim_rng;
         strb     = (v[3:0] == 4'h0) ? 4'hf : v[3:0];
         issue(1, a, v, strb, acc);
         check("ext write addr", 32'(a[17:2]), 32'(ext_log[$].addr));
         check("ext write data", v, ext_log[$].wdata);
         check("ext write strb", 32'({1'b1, strb}), 32'({ext_log[$].we, ext_log[$].wstrb}));
         read(1, a, d, acc, rv);
         check("ext read addr", 32'({1'b0, a[17:2]}), 32'({ext_log[$].we, ext_log[$].addr}));
         check("ext dbus data", ext_word(32'(a[17:2])), d);
         read(0, a, d, acc, rv);
         check("ext ibus data", ext_word(32'(a[17:2])), d);
      end
      end_test();

      start_test("arbitration");
      n = ext_log.size();
      fork
         read(0, 32'h8000_0040, d, acc, rv);
         read(1, 32'h8000_0080, d2, acc2, rv2);
      join
      check("arb first grant", 32'h20, 32'(ext_log[n].addr));
      check("arb second grant", 32'h10, 32'(ext_log[n+1].addr));
      check("arb ibus data", ext_word(32'h10), d);
      check("arb dbus data", ext_word(32'h20), d2);
      end_test();

      start_test("periph");
      issue(1, 32'h4000_0000, 32'hdead_beef, 4'hf, acc);
      read(1, 32'h4000_0000, d, acc, rv);
      check("scratch readback", 32'hdead_beef, d);
      issue(1, 32'h4000_0008, 32'h0000_00a5, 4'h1, acc);
      check("gpio output", 32'ha5, 32'(gpio_o));
      read(1, 32'h4000_0004, d, acc, rv);
      repeat (7) @(negedge clk_i);
      read(1, 32'h4000_0004, d2, acc2, rv2);
      check("timer delta", acc2 - acc, d2 - d);
      end_test();

      start_test("ordering");
      issue(1, 32'h8000_0100, '0, '0, acc);
      issue(1, 32'h0000_0100, '0, '0, acc2);
      take(1, d, rv);
      take(1, d2, rv2);
      check("order ext data", ext_word(32'h40), d);
      check("order sram data", sram_ref[0], d2);
      check("order ext latency", 1, rv - acc + 1);
      check("order sram latency", 1, rv2 - acc2 + 1);
      end_test();

      $display("tests: %0d, failed tests: %0d, checks: %0d, errors: %0d",
               tests, failed_tests, checks, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verilog/ext_mem.sv */
`default_nettype none

`include "iob_soc_consts.svh"

module ext_mem (
   input  wire                         clk_i,
   input  wire                         rst_n_i,
   input  wire iob_soc_pkg::iob_req_t  i_req_i,
   output iob_soc_pkg::iob_resp_t      i_resp_o,
   input  wire iob_soc_pkg::iob_req_t  d_req_i,
   output iob_soc_pkg::iob_resp_t      d_resp_o,
   // external request/acknowledge port
   output iob_soc_pkg::ext_req_t       ext_req_o,
   input  wire                         ext_ack_i,
   input  wire [`DATA_W-1:0]           ext_rdata_i
);
   import iob_soc_pkg::*;

   ext_state_t         state_q;
   ext_req_t           req_q;
   logic               valid_q;
   logic               i_rvalid_q;
   logic               d_rvalid_q;
   logic [`DATA_W-1:0] rdata_q;
   logic               busy;

   // native request to word addressed external request
   function automatic ext_req_t to_ext(iob_req_t r);
      ext_req_t e;
      e.valid = r.avalid;
      e.we    = |r.wstrb;
      e.addr  = r.addr[`EXT_ADDR_W+1:2];
      e.wdata = r.wdata;
      e.wstrb = r.wstrb;
      return e;
   endfunction

   assign busy = (state_q != EXT_IDLE);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q    <= EXT_IDLE;
         valid_q    <= 1'b0;
         i_rvalid_q <= 1'b0;
         d_rvalid_q <= 1'b0;
      end else begin
         i_rvalid_q <= 1'b0;
         d_rvalid_q <= 1'b0;
         case (state_q)
            EXT_IDLE: begin
               // data port has fixed priority
               if (d_req_i.avalid) begin
                  state_q <= EXT_BUSY_D;
                  valid_q <= 1'b1;
               end else if (i_req_i.avalid) begin
                  state_q <= EXT_BUSY_I;
                  valid_q <= 1'b1;
               end
            end
            EXT_BUSY_I, EXT_BUSY_D: begin
               if (ext_ack_i) begin
                  state_q    <= EXT_IDLE;
                  valid_q    <= 1'b0;
                  i_rvalid_q <= (state_q == EXT_BUSY_I) && !req_q.we;
                  d_rvalid_q <= (state_q == EXT_BUSY_D) && !req_q.we;
               end
            end
            default: state_q <= EXT_IDLE;
         endcase
      end
   end

   // granted request and read data capture
   always_ff @(posedge clk_i) begin
      if (!busy) begin
         req_q <= d_req_i.avalid ? to_ext(d_req_i) : to_ext(i_req_i);
      end
      if (busy && ext_ack_i) begin
         rdata_q <= ext_rdata_i;
      end
   end

   always_comb begin
      ext_req_o       = req_q;
      ext_req_o.valid = valid_q;
   end

   // a port is accepted only on its own acknowledge
   assign i_resp_o = '{rdata: rdata_q, rvalid: i_rvalid_q,
                       ready: (state_q == EXT_BUSY_I) && ext_ack_i};
   assign d_resp_o = '{rdata: rdata_q, rvalid: d_rvalid_q,
                       ready: (state_q == EXT_BUSY_D) && ext_ack_i};

endmodule

`default_nettype wire

/* verilog/int_mem.sv */
`default_nettype none

`include "iob_soc_consts.svh"

module int_mem (
   input  wire                         clk_i,
   // instruction port, reads only
   input  wire iob_soc_pkg::iob_req_t  i_req_i,
   output iob_soc_pkg::iob_resp_t      i_resp_o,
   // data port
   input  wire iob_soc_pkg::iob_req_t  d_req_i,
   output iob_soc_pkg::iob_resp_t      d_resp_o
);
   import iob_soc_pkg::*;

   logic [`DATA_W-1:0]     mem[(1 << `SRAM_ADDR_W)];
   logic [`SRAM_ADDR_W-1:0] i_addr;
   logic [`SRAM_ADDR_W-1:0] d_addr;
   logic [`DATA_W-1:0]     i_rdata_q;
   logic [`DATA_W-1:0]     d_rdata_q;
   logic                   i_rvalid_q;
   logic                   d_rvalid_q;

   // word index, byte offset dropped
   assign i_addr = i_req_i.addr[`SRAM_ADDR_W+1:2];
   assign d_addr = d_req_i.addr[`SRAM_ADDR_W+1:2];

   always_ff @(posedge clk_i) begin
      i_rdata_q  <= mem[i_addr];
      i_rvalid_q <= i_req_i.avalid && (i_req_i.wstrb == '0);
   end

   // reads see the word as it was before this edge
   always_ff @(posedge clk_i) begin
      if (d_req_i.avalid) begin
         for (int b = 0; b < `DATA_W / 8; b++) begin
            if (d_req_i.wstrb[b]) begin
               mem[d_addr][8*b+:8] <= d_req_i.wdata[8*b+:8];
            end
         end
      end
      d_rdata_q  <= mem[d_addr];
      d_rvalid_q <= d_req_i.avalid && (d_req_i.wstrb == '0);
   end

   assign i_resp_o = '{rdata: i_rdata_q, rvalid: i_rvalid_q, ready: 1'b1};
   assign d_resp_o = '{rdata: d_rdata_q, rvalid: d_rvalid_q, ready: 1'b1};

endmodule

`default_nettype wire

/* verilog/iob_soc.sv */
`default_nettype none

`include "iob_soc_consts.svh"

module iob_soc (
   input  wire                         clk_i,
   input  wire                         rst_n_i,
   // cpu instruction and data buses
   input  wire iob_soc_pkg::iob_req_t  ibus_req_i,
   output iob_soc_pkg::iob_resp_t      ibus_resp_o,
   input  wire iob_soc_pkg::iob_req_t  dbus_req_i,
   output iob_soc_pkg::iob_resp_t      dbus_resp_o,
   // external memory port
   output iob_soc_pkg::ext_req_t       ext_req_o,
   input  wire                         ext_ack_i,
   input  wire [`DATA_W-1:0]           ext_rdata_i,
   output logic [`GPIO_W-1:0]          gpio_o
);
   import iob_soc_pkg::*;

   // instruction side
   iob_req_t  int_mem_i_req;
   iob_resp_t int_mem_i_resp;
   iob_req_t  ext_mem_i_req;
   iob_resp_t ext_mem_i_resp;

   // data side, internal part splits again below
   iob_req_t  int_d_req;
   iob_resp_t int_d_resp;
   iob_req_t  ext_mem_d_req;
   iob_resp_t ext_mem_d_resp;
   iob_req_t  sram_d_req;
   iob_resp_t sram_d_resp;
   iob_req_t  periph_req;
   iob_resp_t periph_resp;

   iob_split #(.SEL_BIT(`E_BIT)) ibus_split (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .m_req_i  (ibus_req_i),
      .m_resp_o (ibus_resp_o),
      .s0_req_o (int_mem_i_req),
      .s1_req_o (ext_mem_i_req),
      .s0_resp_i(int_mem_i_resp),
      .s1_resp_i(ext_mem_i_resp)
   );

   iob_split #(.SEL_BIT(`E_BIT)) dbus_split (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .m_req_i  (dbus_req_i),
      .m_resp_o (dbus_resp_o),
      .s0_req_o (int_d_req),
      .s1_req_o (ext_mem_d_req),
      .s0_resp_i(int_d_resp),
      .s1_resp_i(ext_mem_d_resp)
   );

   // sram below P_BIT, peripherals above
   iob_split #(.SEL_BIT(`P_BIT)) pbus_split (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .m_req_i  (int_d_req),
      .m_resp_o (int_d_resp),
      .s0_req_o (sram_d_req),
      .s1_req_o (periph_req),
      .s0_resp_i(sram_d_resp),
      .s1_resp_i(periph_resp)
   );

   int_mem int_mem0 (
      .clk_i   (clk_i),
      .i_req_i (int_mem_i_req),
      .i_resp_o(int_mem_i_resp),
      .d_req_i (sram_d_req),
      .d_resp_o(sram_d_resp)
   );

   ext_mem ext_mem0 (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .i_req_i    (ext_mem_i_req),
      .i_resp_o   (ext_mem_i_resp),
      .d_req_i    (ext_mem_d_req),
      .d_resp_o   (ext_mem_d_resp),
      .ext_req_o  (ext_req_o),
      .ext_ack_i  (ext_ack_i),
      .ext_rdata_i(ext_rdata_i)
   );

   periph_regs periph0 (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .req_i  (periph_req),
      .resp_o (periph_resp),
      .gpio_o (gpio_o)
   );

endmodule

`default_nettype wire

/* verilog/iob_soc_pkg.sv */
`default_nettype none

`include "iob_soc_consts.svh"

package iob_soc_pkg;

   // native bus request, a write when wstrb is nonzero
   typedef struct packed {
      logic                   avalid;
      logic [  `ADDR_W-1:0]   addr;
      logic [  `DATA_W-1:0]   wdata;
      logic [`DATA_W/8-1:0]   wstrb;
   } iob_req_t;

   typedef struct packed {
      logic [`DATA_W-1:0] rdata;
      logic               rvalid;
      logic               ready;
   } iob_resp_t;

   // word addressed request toward the external memory
   typedef struct packed {
      logic                   valid;
      logic                   we;
      logic [`EXT_ADDR_W-1:0] addr;
      logic [    `DATA_W-1:0] wdata;
      logic [  `DATA_W/8-1:0] wstrb;
   } ext_req_t;

   typedef enum logic [1:0] {EXT_IDLE, EXT_BUSY_I, EXT_BUSY_D} ext_state_t;

endpackage

`default_nettype wire

/* verilog/iob_split.sv */
`default_nettype none

module iob_split #(
   parameter int SEL_BIT = 0
) (
   input  wire                         clk_i,
   input  wire                         rst_n_i,
   // master side
   input  wire iob_soc_pkg::iob_req_t  m_req_i,
   output iob_soc_pkg::iob_resp_t      m_resp_o,
   // slave 0 takes select bit low, slave 1 takes it high
   output iob_soc_pkg::iob_req_t       s0_req_o,
   output iob_soc_pkg::iob_req_t       s1_req_o,
   input  wire iob_soc_pkg::iob_resp_t s0_resp_i,
   input  wire iob_soc_pkg::iob_resp_t s1_resp_i
);
   import iob_soc_pkg::*;

   logic sel;
   logic pend_q;
   logic pend_sel_q;
   logic pend_rvalid;
   logic blocked;
   logic accept;

   assign sel = m_req_i.addr[SEL_BIT];

   // rvalid from the slave that owns the outstanding read
   assign pend_rvalid = pend_sel_q ? s1_resp_i.rvalid : s0_resp_i.rvalid;
   // hold off new requests until that read has come back
   assign blocked = pend_q && !pend_rvalid;

   always_comb begin
      s0_req_o        = m_req_i;
      s1_req_o        = m_req_i;
      s0_req_o.avalid = m_req_i.avalid && !sel && !blocked;
      s1_req_o.avalid = m_req_i.avalid && sel && !blocked;
   end

   always_comb begin
      m_resp_o.ready  = (sel ? s1_resp_i.ready : s0_resp_i.ready) && !blocked;
      m_resp_o.rvalid = pend_q && pend_rvalid;
      m_resp_o.rdata  = pend_sel_q ? s1_resp_i.rdata : s0_resp_i.rdata;
   end

   assign accept = m_req_i.avalid && m_resp_o.ready;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         pend_q     <= 1'b0;
         pend_sel_q <= 1'b0;
      end else if (accept && (m_req_i.wstrb == '0)) begin
         // a new read replaces one that completes this cycle
         pend_q     <= 1'b1;
         pend_sel_q <= sel;
      end else if (pend_rvalid) begin
         pend_q <= 1'b0;
      end
   end

endmodule

`default_nettype wire

/* verilog/periph_regs.sv */
`default_nettype none

`include "iob_soc_consts.svh"

module periph_regs (
   input  wire                         clk_i,
   input  wire                         rst_n_i,
   input  wire iob_soc_pkg::iob_req_t  req_i,
   output iob_soc_pkg::iob_resp_t      resp_o,
   output logic [`GPIO_W-1:0]          gpio_o
);
   import iob_soc_pkg::*;

   logic [`P_BIT-3:0]  offs;
   logic [`DATA_W-1:0] scratch_q;
   logic [`DATA_W-1:0] timer_q;
   logic [`DATA_W-1:0] rd_mux;
   logic [`DATA_W-1:0] rdata_q;
   logic               rvalid_q;
   logic               wr;

   // word offset inside the peripheral window
   assign offs = req_i.addr[`P_BIT-1:2];
   assign wr   = req_i.avalid && (req_i.wstrb != '0);

   always_comb begin
      rd_mux = '0;
      if (offs == `REG_SCRATCH) rd_mux = scratch_q;
      else if (offs == `REG_TIMER) rd_mux = timer_q;
      else if (offs == `REG_GPIO) rd_mux = {{(`DATA_W - `GPIO_W) {1'b0}}, gpio_o};
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         timer_q  <= '0;
         gpio_o   <= '0;
         rvalid_q <= 1'b0;
      end else begin
         // free running, writes are ignored
         timer_q  <= timer_q + 1'b1;
         rvalid_q <= req_i.avalid && !wr;
         if (wr && (offs == `REG_GPIO) && req_i.wstrb[0]) gpio_o <= req_i.wdata[`GPIO_W-1:0];
      end
   end

   always_ff @(posedge clk_i) begin
      if (wr && (offs == `REG_SCRATCH)) begin
         for (int b = 0; b < `DATA_W / 8; b++) begin
            if (req_i.wstrb[b]) scratch_q[8*b+:8] <= req_i.wdata[8*b+:8];
         end
      end
      rdata_q <= rd_mux;
   end

   assign resp_o = '{rdata: rdata_q, rvalid: rvalid_q, ready: 1'b1};

endmodule

`default_nettype wire
